// File: all.f
+incdir+.
ppu_pkg.sv
ppu_regs.sv
ppu_timing.sv
bg_fetcher.sv
plane_shifter.sv
pixel_pusher.sv
ppu_top.sv
ppu_properties.sv
tb_ppu.sv

// File: Bender.yml
package:
  name: bg_ppu

sources:
  - include_dirs:
      - .
    files:
      - ppu_pkg.sv
      - ppu_regs.sv
      - ppu_timing.sv
      - bg_fetcher.sv
      - plane_shifter.sv
      - pixel_pusher.sv
      - ppu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - ppu_properties.sv
      - tb_ppu.sv

// File: tb_ppu.sv
// testbench for the background ppu with vram model, reference pixel model, checks and timeout
`timescale 1ns/1ps
`include "ppu_defines.svh"

module tb_ppu;
    import ppu_pkg::*;

    localparam int FRAME_CYCLES = (`LAST_LY + 1) * `LINE_DOTS;
    localparam int MAX_CYCLES = 2 * FRAME_CYCLES + 10000; // one frame test, short line tests, margin

    logic clk;
    logic rst;
    addr_t bus_addr;
    logic bus_wr;
    logic bus_rd;
    byte_t bus_wdata;
    byte_t bus_rdata;
    logic vram_rd;
    addr_t vram_addr;
    byte_t vram_data;
    ppu_mode_t mode;
    logic irq_vblank;
    logic irq_lcdc;
    color_t px_out;
    logic px_valid;

    byte_t vram [0:8191]; // 8000 to 9FFF
    addr_t rd_addr [`VRAM_LATENCY];
    logic rd_vld [`VRAM_LATENCY];
    integer seed;
    int cycles = 0;
    int checks = 0;
    int value_errs = 0;
    int other_errs = 0;
    byte_t sh_lcdc = '0; // register values as written by the testbench
    byte_t sh_scx = '0;
    byte_t sh_scy = '0;
    byte_t sh_stat = '0;
    byte_t sh_lyc = '0;
    byte_t sh_bgp = '0;
    logic checking = 1'b0; // pixel compare enable
    int cur_line = 0;
    int cur_x = 0;
    ppu_mode_t prev_mode = scan;

    ppu_top DUT (
        .clk(clk), .rst(rst), .bus_addr(bus_addr), .bus_wr(bus_wr), .bus_rd(bus_rd),
        .bus_wdata(bus_wdata), .bus_rdata(bus_rdata), .vram_rd(vram_rd), .vram_addr(vram_addr),
        .vram_data(vram_data), .mode(mode), .irq_vblank(irq_vblank), .irq_lcdc(irq_lcdc),
        .px_out(px_out), .px_valid(px_valid)
    );

    bind ppu_top ppu_properties u_props (
        .clk(clk), .rst(rst), .mode(mode), .ly(ly), .px_valid(px_valid), .vram_rd(vram_rd),
        .load(load), .draw_done(draw_done), .fetch_state(u_fetcher.state)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        seed = 94;
        vram_data = '0;
        for (int i = 0; i < 8192; i++) begin
            vram[i] = $random(seed);
        end
        for (int i = 0; i < `VRAM_LATENCY; i++) begin
            rd_vld[i] = 1'b0;
        end
    end

    // vram answers a strobe VRAM_LATENCY cycles later
    always @(negedge clk) begin
        if (rd_vld[`VRAM_LATENCY-1]) begin
            vram_data = vram[rd_addr[`VRAM_LATENCY-1][12:0]];
        end
        for (int i = `VRAM_LATENCY - 1; i > 0; i--) begin
            rd_addr[i] = rd_addr[i-1];
            rd_vld[i] = rd_vld[i-1];
        end
        rd_addr[0] = vram_addr;
        rd_vld[0] = vram_rd;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic color_t ref_color(input int line, input int x, input byte_t lc,
                                         input byte_t sx, input byte_t sy);
        byte_t y;
        byte_t px;
        byte_t entry;
        addr_t map_a;
        addr_t tile_a;
        addr_t row_a;
        int off;
        int b;
        if (!lc[0]) begin
            return 2'd0; // background disabled
        end
        y = line + sy;
        px = x + sx;
        map_a = (lc[3] ? `VRAM_MAP1_BASE : `VRAM_MAP0_BASE) + 32 * (y / 8) + (px / 8) % 32;
        entry = vram[map_a[12:0]];
        off = entry;
        if (lc[4]) begin
            tile_a = `VRAM_TILE_BASE + 16 * off;
        end else begin
            if (entry[7]) begin
                off = off - 256; // signed tile number around 9000
            end
            tile_a = 'h9000 + 16 * off;
        end
        row_a = tile_a + 2 * y[2:0];
        b = 7 - px[2:0];
        return {vram[row_a[12:0] + 1][b], vram[row_a[12:0]][b]};
    endfunction

    function automatic byte_t stat_value(input byte_t line, input ppu_mode_t m);
        return {1'b1, sh_stat[6:3], line == sh_lyc, m};
    endfunction

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            value_errs++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_color(input string name, input color_t got, input color_t exp);
        checks++;
        if (got !== exp) begin
            value_errs++;
            $display("** Error: %s = %h, expected %h at line %0d x %0d", name, got, exp,
                     cur_line, cur_x);
        end
    endtask

    task automatic check_mode(input string name, input ppu_mode_t got, input ppu_mode_t exp);
        checks++;
        if (got !== exp) begin
            value_errs++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // compare every valid pixel with the reference and count pixels per line
    always @(negedge clk) begin
        if (!checking || mode == vblank) begin
            cur_line = 0;
            cur_x = 0;
        end else begin
            if (px_valid) begin
                check_color("px_out", px_out, ref_color(cur_line, cur_x, sh_lcdc, sh_scx, sh_scy));
                cur_x++;
            end
            if (prev_mode == draw && mode != draw) begin
                check_byte("pixels per line", byte_t'(cur_x), byte_t'(`SCREEN_W));
                cur_line++;
                cur_x = 0;
            end
        end
        prev_mode = mode;
    end

    task automatic bus_write(input addr_t addr, input byte_t data);
        @(negedge clk);
        bus_addr = addr;
        bus_wdata = data;
        bus_wr = 1'b1;
        bus_rd = 1'b0;
        case (addr)
            `PPU_REG_LCDC: sh_lcdc = data;
            `PPU_REG_STAT: sh_stat = data;
            `PPU_REG_SCY: sh_scy = data;
            `PPU_REG_SCX: sh_scx = data;
            `PPU_REG_LYC: sh_lyc = data;
            `PPU_REG_BGP: sh_bgp = data;
            default: ;
        endcase
        @(negedge clk);
        bus_wr = 1'b0;
    endtask

    task automatic bus_read(input addr_t addr, output byte_t data);
        @(negedge clk);
        bus_addr = addr;
        bus_rd = 1'b1;
        @(negedge clk);
        data = bus_rdata;
        bus_rd = 1'b0;
    endtask

    task automatic test_registers();
        byte_t d;
        bus_write(`PPU_REG_LCDC, 8'h13); // display stays off
        bus_write(`PPU_REG_SCY, 8'h5A);
        bus_write(`PPU_REG_SCX, 8'hA5);
        bus_write(`PPU_REG_LYC, 8'h3C);
        bus_write(`PPU_REG_BGP, 8'hE4);
        bus_read(`PPU_REG_LCDC, d);
        check_byte("LCDC", d, sh_lcdc);
        bus_read(`PPU_REG_SCY, d);
        check_byte("SCY", d, sh_scy);
        bus_read(`PPU_REG_SCX, d);
        check_byte("SCX", d, sh_scx);
        bus_read(`PPU_REG_LYC, d);
        check_byte("LYC", d, sh_lyc);
        bus_read(`PPU_REG_BGP, d);
        check_byte("BGP", d, sh_bgp);
        bus_read(`PPU_REG_DMA, d);
        check_byte("FF46 read", d, 8'hFF);
        bus_read(16'hFF48, d);
        check_byte("FF48 read", d, 8'hFF);
        bus_read(16'h1234, d);
        check_byte("1234 read", d, 8'hFF);
        bus_write(`PPU_REG_LY, 8'h55);
        bus_read(`PPU_REG_LY, d);
        check_byte("LY", d, 8'h00);
        bus_write(`PPU_REG_STAT, 8'hFF);
        bus_read(`PPU_REG_STAT, d);
        check_byte("STAT", d, stat_value(8'h00, scan));
        check_byte("irq_lcdc", byte_t'(irq_lcdc), 8'h01); // scan enable set while off
        bus_write(`PPU_REG_STAT, 8'h00);
        bus_read(`PPU_REG_STAT, d);
        check_byte("STAT", d, stat_value(8'h00, scan));
    endtask

    task automatic run_lines(input byte_t lc, input byte_t sx, input byte_t sy, input int n);
        bus_write(`PPU_REG_SCX, sx);
        bus_write(`PPU_REG_SCY, sy);
        checking = 1'b1;
        bus_write(`PPU_REG_LCDC, lc);
        while (cur_line < n) begin
            @(negedge clk);
        end
        checking = 1'b0;
        bus_write(`PPU_REG_LCDC, lc & 8'h7F);
    endtask

    // ly and mode follow from the cycle count since the display came on
    task automatic test_frame();
        int exp_ly;
        int exp_dot;
        bus_write(`PPU_REG_STAT, 8'h10); // vblank source only
        bus_write(`PPU_REG_SCX, 8'h0D);
        bus_write(`PPU_REG_SCY, 8'h27);
        checking = 1'b1;
        bus_write(`PPU_REG_LCDC, 8'h91);
        bus_addr = `PPU_REG_LY;
        bus_rd = 1'b1;
        bus_wdata = 8'h55;
        for (int k = 2; k <= FRAME_CYCLES + 2 * `LINE_DOTS; k++) begin
            @(negedge clk);
            bus_wr = (k == `LINE_DOTS + 100); // ly ignores a write in the middle of line 1
            exp_ly = ((k - 1) / `LINE_DOTS) % (`LAST_LY + 1);
            exp_dot = (k - 1) % `LINE_DOTS;
            check_byte("LY", bus_rdata, byte_t'(exp_ly));
            check_byte("irq_vblank", byte_t'(irq_vblank), byte_t'(exp_ly >= `VISIBLE_LINES));
            check_byte("irq_lcdc", byte_t'(irq_lcdc), byte_t'(exp_ly >= `VISIBLE_LINES));
            if (exp_ly >= `VISIBLE_LINES) begin
                check_mode("mode", mode, vblank);
            end else if (exp_dot < `SCAN_DOTS) begin
                check_mode("mode", mode, scan);
            end else if (mode != draw && mode != hblank) begin
                value_errs++;
                $display("** Error: mode = %h, expected draw or hblank at %0t", mode, $time);
            end
        end
        bus_wr = 1'b0;
        bus_rd = 1'b0;
        checking = 1'b0;
        bus_write(`PPU_REG_LCDC, 8'h11);
    endtask

    task automatic test_stat();
        logic coinc;
        logic exp_irq;
        int start;
        int dot;
        bus_write(`PPU_REG_LYC, 8'd5);
        bus_write(`PPU_REG_STAT, 8'h40); // coincidence source
        bus_write(`PPU_REG_LCDC, 8'h91);
        start = cycles; // dot 0 of line 0
        bus_addr = `PPU_REG_STAT;
        bus_rd = 1'b1;
        for (int k = 2; k <= 8 * `LINE_DOTS; k++) begin
            @(negedge clk);
            coinc = ((k - 1) / `LINE_DOTS) == 5;
            check_byte("irq_lcdc", byte_t'(irq_lcdc), byte_t'(coinc));
            check_byte("STAT[2]", byte_t'(bus_rdata[2]), byte_t'(coinc));
            check_byte("STAT[7]", byte_t'(bus_rdata[7]), 8'h01);
        end
        bus_rd = 1'b0;
        bus_write(`PPU_REG_STAT, 8'h08);
        repeat (2 * `LINE_DOTS) begin
            @(negedge clk);
            exp_irq = (mode == hblank);
            check_byte("irq_lcdc", byte_t'(irq_lcdc), byte_t'(exp_irq));
        end
        bus_write(`PPU_REG_STAT, 8'h20);
        repeat (2 * `LINE_DOTS) begin
            @(negedge clk);
            dot = (cycles - start) % `LINE_DOTS;
            exp_irq = (dot < `SCAN_DOTS); // these lines are all visible
            check_byte("irq_lcdc", byte_t'(irq_lcdc), byte_t'(exp_irq));
        end
        bus_write(`PPU_REG_STAT, 8'h00);
    endtask

    task automatic test_display_off();
        bus_write(`PPU_REG_LCDC, 8'h11); // turned off in the middle of a frame
        @(negedge clk);
        bus_addr = `PPU_REG_LY;
        bus_rd = 1'b1;
        repeat (1000) begin
            @(negedge clk);
            check_byte("LY", bus_rdata, 8'h00);
            check_mode("mode", mode, scan);
            if (px_valid || vram_rd) begin
                other_errs++;
                $display("pixel output or vram read while the display is off at %0t", $time);
            end
        end
        bus_rd = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        bus_addr = '0;
        bus_wr = 1'b0;
        bus_rd = 1'b0;
        bus_wdata = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        test_registers();
        run_lines(8'h91, 8'h00, 8'h00, 3);
        run_lines(8'h91, 8'h05, 8'h0B, 3);
        run_lines(8'h91, 8'hF3, 8'hFA, 3); // both scrolls wrap
        run_lines(8'h81, 8'h2A, 8'h11, 3);
        run_lines(8'h89, 8'h07, 8'h40, 3);
        run_lines(8'h99, 8'h10, 8'h03, 3);
        run_lines(8'h90, 8'h04, 8'h00, 2);
        test_frame();
        test_stat();
        test_display_off();
        $display("checks %0d, value errors %0d, other errors %0d", checks, value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: ppu_properties.sv
// concurrent assertions on modes, line counter, vram strobes and the fetcher handoff
`timescale 1ns/1ps

module ppu_properties (
    input logic                  clk,
    input logic                  rst,
    input ppu_pkg::ppu_mode_t    mode,
    input ppu_pkg::ly_t          ly,
    input logic                  px_valid,
    input logic                  vram_rd,
    input logic                  load,
    input logic                  draw_done,
    input ppu_pkg::fetch_state_t fetch_state
);
    import ppu_pkg::*;

    a_px_in_draw: assert property (@(posedge clk) disable iff (rst) px_valid |-> mode == draw)
        else $error("px_valid outside draw");

    a_rd_in_draw: assert property (@(posedge clk) disable iff (rst) vram_rd |-> mode == draw)
        else $error("vram_rd outside draw");

    a_draw_visible: assert property (@(posedge clk) disable iff (rst) mode == draw |-> ly < 144)
        else $error("draw on a vblank line");

    a_ly_range: assert property (@(posedge clk) disable iff (rst) ly <= 153)
        else $error("ly beyond the last line");

    // a load only takes a row while the line is drawn
    a_load_row: assert property (@(posedge clk) disable iff (rst)
        load |-> mode == draw)
        else $error("load outside draw");

    a_done_fetched: assert property (@(posedge clk) disable iff (rst)
        draw_done |-> fetch_state == idle) // every tile of the line was fetched
        else $error("draw_done while the fetcher is busy");

endmodule

// File: ppu_top.sv
// ppu top level wiring registers, timing, fetcher, shifters and pixel pusher
`timescale 1ns/1ps
`include "ppu_defines.svh"

module ppu_top (
    input  logic               clk,
    input  logic               rst,
    input  ppu_pkg::addr_t     bus_addr,
    input  logic               bus_wr,
    input  logic               bus_rd,
    input  ppu_pkg::byte_t     bus_wdata,
    output ppu_pkg::byte_t     bus_rdata,
    output logic               vram_rd,
    output ppu_pkg::addr_t     vram_addr,
    input  ppu_pkg::byte_t     vram_data,
    output ppu_pkg::ppu_mode_t mode,
    output logic               irq_vblank,
    output logic               irq_lcdc,
    output ppu_pkg::color_t    px_out,
    output logic               px_valid
);
    import ppu_pkg::*;

    byte_t lcdc;
    byte_t scx;
    byte_t scy;
    ly_t ly;
    logic line_start;
    logic draw_done;
    logic pipe_rst;
    logic load;
    logic shift;
    logic row_ready;
    byte_t row_lo;
    byte_t row_hi;
    byte_t rows [`NUM_PLANES];
    logic [`NUM_PLANES-1:0] plane_bits;

    assign pipe_rst = rst || !lcdc[7]; // display off flushes the pixel path
    assign rows[0] = row_lo;
    assign rows[1] = row_hi;

    ppu_regs u_regs (
        .clk(clk), .rst(rst), .bus_addr(bus_addr), .bus_wr(bus_wr), .bus_rd(bus_rd),
        .bus_wdata(bus_wdata), .mode(mode), .ly(ly), .bus_rdata(bus_rdata),
        .lcdc(lcdc), .scx(scx), .scy(scy), .irq_lcdc(irq_lcdc)
    );

    ppu_timing u_timing (
        .clk(clk), .rst(rst), .lcdc_on(lcdc[7]), .draw_done(draw_done), .mode(mode),
        .ly(ly), .line_start(line_start), .irq_vblank(irq_vblank)
    );

    bg_fetcher u_fetcher (
        .clk(clk), .rst(pipe_rst), .line_start(line_start), .load(load), .ly(ly),
        .scx(scx), .scy(scy), .lcdc(lcdc), .vram_data(vram_data), .vram_rd(vram_rd),
        .vram_addr(vram_addr), .row_lo(row_lo), .row_hi(row_hi), .row_ready(row_ready)
    );

    for (genvar p = 0; p < `NUM_PLANES; p++) begin : g_plane
        plane_shifter u_shifter (
            .clk(clk), .rst(pipe_rst), .load(load), .shift(shift), .row(rows[p]),
            .bit_out(plane_bits[p])
        );
    end

    pixel_pusher u_pusher (
        .clk(clk), .rst(pipe_rst), .line_start(line_start), .row_ready(row_ready),
        .scx(scx), .plane_bits(plane_bits), .load(load), .shift(shift),
        .px_out(px_out), .px_valid(px_valid), .draw_done(draw_done)
    );

endmodule

// File: pixel_pusher.sv
// pixel pusher that drains the shifters, drops fine-scroll pixels and counts the line
`timescale 1ns/1ps
`include "ppu_defines.svh"

module pixel_pusher (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   line_start,
    input  logic                   row_ready,
    input  ppu_pkg::byte_t         scx,
    input  logic [`NUM_PLANES-1:0] plane_bits,
    output logic                   load,
    output logic                   shift,
    output ppu_pkg::color_t        px_out,
    output logic                   px_valid,
    output logic                   draw_done
);
    logic active; // line in progress
    logic [3:0] left; // pixels still in the shifters
    logic [2:0] discard; // fine scroll pixels still to drop
    logic [7:0] px_cnt;

    assign load = active && (left == 4'd0) && row_ready;
    assign shift = active && (left != 4'd0);
    assign px_out = plane_bits; // {high plane, low plane}
    assign px_valid = shift && (discard == 3'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            left <= '0;
            discard <= '0;
            px_cnt <= '0;
            draw_done <= 1'b0;
        end else begin
            draw_done <= 1'b0;
            if (line_start) begin
                active <= 1'b1;
                left <= '0;
                discard <= scx[2:0];
                px_cnt <= '0;
            end else if (load) begin
                left <= 4'(`TILE_W);
            end else if (shift) begin
                left <= left - 4'd1;
                if (discard != 3'd0) begin
                    discard <= discard - 3'd1;
                end else begin
                    px_cnt <= px_cnt + 8'd1;
                    if (px_cnt == 8'(`SCREEN_W - 1)) begin
                        active <= 1'b0; // last visible pixel of the line
                        draw_done <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: plane_shifter.sv
// shift register for one bitplane of the current tile row
`timescale 1ns/1ps

module plane_shifter (
    input  logic           clk,
    input  logic           rst,
    input  logic           load,
    input  logic           shift,
    input  ppu_pkg::byte_t row,
    output logic           bit_out
);
    import ppu_pkg::*;

    byte_t bits;

    always_ff @(posedge clk) begin
        if (rst) begin
            bits <= '0;
        end else if (load) begin
            bits <= row;
        end else if (shift) begin
            bits <= {bits[6:0], 1'b0}; // leftmost pixel first
        end
    end

    assign bit_out = bits[7];

endmodule

// File: bg_fetcher.sv
// background tile fetcher with vram reads, scrolling and one held tile row
`timescale 1ns/1ps
`include "ppu_defines.svh"

module bg_fetcher (
    input  logic           clk,
    input  logic           rst,
    input  logic           line_start,
    input  logic           load,
    input  ppu_pkg::ly_t   ly,
    input  ppu_pkg::byte_t scx,
    input  ppu_pkg::byte_t scy,
    input  ppu_pkg::byte_t lcdc,
    input  ppu_pkg::byte_t vram_data,
    output logic           vram_rd,
    output ppu_pkg::addr_t vram_addr,
    output ppu_pkg::byte_t row_lo,
    output ppu_pkg::byte_t row_hi,
    output logic           row_ready
);
    import ppu_pkg::*;

    localparam int SCREEN_TILES = `SCREEN_W / `TILE_W;

    fetch_state_t state;
    logic [$clog2(`VRAM_LATENCY + 1)-1:0] wait_cnt; // cycles since the strobe
    logic [4:0] tile_cnt;
    logic [4:0] last_tile;
    byte_t entry; // tile number from the map
    byte_t y_pix;
    logic [4:0] map_col;
    addr_t map_base;
    addr_t map_addr;
    addr_t tile_addr;
    addr_t row_addr;
    logic data_valid;

    assign y_pix = ly + scy;
    assign map_col = scx[7:3] + tile_cnt; // wraps at 32 columns
    assign map_base = lcdc[3] ? `VRAM_MAP1_BASE : `VRAM_MAP0_BASE;
    assign map_addr = map_base + {6'b0, y_pix[7:3], map_col};

    // unsigned indexing from 8000 or signed indexing around 9000
    assign tile_addr = lcdc[4] ? (`VRAM_TILE_BASE + {4'b0, entry, 4'b0}) :
                       (`VRAM_TILE_BASE + 16'h1000 + {{4{entry[7]}}, entry, 4'b0});
    assign row_addr = tile_addr + {12'b0, y_pix[2:0], 1'b0};

    // one extra tile covers the pixels dropped by fine scroll
    assign last_tile = 5'(SCREEN_TILES) + {4'b0, (scx[2:0] != 3'd0)};

    assign data_valid = (wait_cnt == `VRAM_LATENCY);
    assign vram_rd = (state inside {map_read, low_read, high_read}) && (wait_cnt == '0);
    assign row_ready = (state == ready);

    always_comb begin
        case (state)
            low_read: vram_addr = row_addr;
            high_read: vram_addr = row_addr + 16'd1;
            default: vram_addr = map_addr;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            wait_cnt <= '0;
            tile_cnt <= '0;
        end else if (line_start) begin
            state <= map_read; // any row left from the last line is dropped
            wait_cnt <= '0;
            tile_cnt <= '0;
        end else begin
            case (state)
                map_read, low_read, high_read: begin
                    if (data_valid) begin
                        wait_cnt <= '0;
                        if (state == map_read) begin
                            state <= low_read;
                        end else if (state == low_read) begin
                            state <= high_read;
                        end else begin
                            state <= ready;
                            tile_cnt <= tile_cnt + 5'd1;
                        end
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                ready: begin
                    if (load) begin
                        // next tile fetch overlaps with the shifters draining
                        state <= (tile_cnt == last_tile) ? idle : map_read;
                    end
                end
                default: ; // idle until the next line
            endcase
        end
    end

    // captured row bytes, blanked when the background is disabled
    always_ff @(posedge clk) begin
        if (data_valid) begin
            case (state)
                map_read: entry <= vram_data;
                low_read: row_lo <= lcdc[0] ? vram_data : 8'h00;
                high_read: row_hi <= lcdc[0] ? vram_data : 8'h00;
                default: ;
            endcase
        end
    end

endmodule

// File: ppu_timing.sv
// scanline timing with dot counter, ly counter, mode fsm and vblank interrupt
`timescale 1ns/1ps
`include "ppu_defines.svh"

module ppu_timing (
    input  logic               clk,
    input  logic               rst,
    input  logic               lcdc_on,
    input  logic               draw_done,
    output ppu_pkg::ppu_mode_t mode,
    output ppu_pkg::ly_t       ly,
    output logic               line_start,
    output logic               irq_vblank
);
    import ppu_pkg::*;

    dot_t dot;

    always_ff @(posedge clk) begin
        if (rst || !lcdc_on) begin
            dot <= '0; // display off holds line 0 in scan
            ly <= '0;
            mode <= scan;
            line_start <= 1'b0;
        end else begin
            line_start <= 1'b0;
            if (dot == dot_t'(`LINE_DOTS - 1)) begin
                // end of line, also cuts a draw that overran
                dot <= '0;
                if (ly == ly_t'(`LAST_LY)) begin
                    ly <= '0;
                    mode <= scan;
                end else begin
                    ly <= ly + 8'd1;
                    if (ly >= ly_t'(`VISIBLE_LINES - 1)) begin
                        mode <= vblank;
                    end else begin
                        mode <= scan;
                    end
                end
            end else begin
                dot <= dot + 9'd1;
                case (mode)
                    scan: begin
                        if (dot == dot_t'(`SCAN_DOTS - 1)) begin
                            mode <= draw;
                            line_start <= 1'b1; // first cycle of draw
                        end
                    end
                    draw: begin
                        if (draw_done) begin
                            mode <= hblank;
                        end
                    end
                    default: ; // hblank and vblank wait for line end
                endcase
            end
        end
    end

    assign irq_vblank = (mode == vblank);

endmodule

// File: ppu_regs.sv
// ppu register file with read mux, stat composition and stat interrupt
`timescale 1ns/1ps
`include "ppu_defines.svh"

module ppu_regs (
    input  logic              clk,
    input  logic              rst,
    input  ppu_pkg::addr_t    bus_addr,
    input  logic              bus_wr,
    input  logic              bus_rd,
    input  ppu_pkg::byte_t    bus_wdata,
    input  ppu_pkg::ppu_mode_t mode,
    input  ppu_pkg::ly_t      ly,
    output ppu_pkg::byte_t    bus_rdata,
    output ppu_pkg::byte_t    lcdc,
    output ppu_pkg::byte_t    scx,
    output ppu_pkg::byte_t    scy,
    output logic              irq_lcdc
);
    import ppu_pkg::*;

    logic [3:0] stat_en; // stat bits 6:3
    byte_t lyc;
    byte_t bgp; // stored only, no palette lookup here
    byte_t stat;
    logic coinc;

    assign coinc = (ly == lyc);
    assign stat = {1'b1, stat_en, coinc, mode};

    always_ff @(posedge clk) begin
        if (rst) begin
            lcdc <= '0; // display off after reset
            stat_en <= '0;
            scy <= '0;
            scx <= '0;
            lyc <= '0;
            bgp <= '0;
        end else if (bus_wr) begin
            case (bus_addr)
                `PPU_REG_LCDC: lcdc <= bus_wdata;
                `PPU_REG_STAT: stat_en <= bus_wdata[6:3]; // low bits are status only
                `PPU_REG_SCY: scy <= bus_wdata;
                `PPU_REG_SCX: scx <= bus_wdata;
                `PPU_REG_LYC: lyc <= bus_wdata;
                `PPU_REG_BGP: bgp <= bus_wdata;
                default: ; // ly and unmapped addresses ignore writes
            endcase
        end
    end

    always_comb begin
        bus_rdata = 8'hFF; // idle bus floats high
        if (bus_rd) begin
            case (bus_addr)
                `PPU_REG_LCDC: bus_rdata = lcdc;
                `PPU_REG_STAT: bus_rdata = stat;
                `PPU_REG_SCY: bus_rdata = scy;
                `PPU_REG_SCX: bus_rdata = scx;
                `PPU_REG_LY: bus_rdata = ly;
                `PPU_REG_LYC: bus_rdata = lyc;
                `PPU_REG_BGP: bus_rdata = bgp;
                default: bus_rdata = 8'hFF;
            endcase
        end
    end

    // coincidence source plus one enable per mode
    assign irq_lcdc = (stat_en[3] && coinc) ||
                      (stat_en[0] && (mode == hblank)) ||
                      (stat_en[1] && (mode == vblank)) ||
                      (stat_en[2] && (mode == scan));

endmodule

// File: ppu_pkg.sv
// ppu package with vector typedefs and the mode and fetch state enums
package ppu_pkg;

    typedef logic [7:0] byte_t; // register and vram data
    typedef logic [15:0] addr_t; // bus and vram address
    typedef logic [8:0] dot_t; // dot within a line
    typedef logic [7:0] ly_t; // line number
    typedef logic [1:0] color_t; // pixel colour index

    // encodings match stat bits 1:0
    typedef enum logic [1:0] {
        hblank = 2'd0,
        vblank = 2'd1,
        scan = 2'd2,
        draw = 2'd3
    } ppu_mode_t;

    typedef enum logic [2:0] {
        idle,
        map_read,
        low_read,
        high_read,
        ready
    } fetch_state_t;

endpackage

// File: ppu_defines.svh
// register addresses, vram bases, line and screen geometry for the background ppu
`ifndef PPU_DEFINES_SVH
`define PPU_DEFINES_SVH

// memory-mapped register addresses
`define PPU_REG_LCDC 16'hFF40
`define PPU_REG_STAT 16'hFF41
`define PPU_REG_SCY 16'hFF42
`define PPU_REG_SCX 16'hFF43
`define PPU_REG_LY 16'hFF44
`define PPU_REG_LYC 16'hFF45
`define PPU_REG_DMA 16'hFF46
`define PPU_REG_BGP 16'hFF47

// vram regions
`define VRAM_TILE_BASE 16'h8000
`define VRAM_MAP0_BASE 16'h9800
`define VRAM_MAP1_BASE 16'h9C00

// line and frame geometry in dots and lines
`define LINE_DOTS 456
`define SCAN_DOTS 80
`define VISIBLE_LINES 144
`define LAST_LY 153
`define SCREEN_W 160
`define TILE_W 8

`define VRAM_LATENCY 2 // strobe to valid data
`define NUM_PLANES 2

`endif
